/* verilog/fabric_cfg.svh */
`default_nettype none
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// Cluster count and index width
`define NUM_CLUSTERS    4
`define CLUSTER_BITS    2

`define WORD_WIDTH      32
`define IO_ADDR_WIDTH   30

// Host tag carries the source cluster above the cluster tag
`define IO_TAG_WIDTH    8
`define HOST_TAG_WIDTH  (`IO_TAG_WIDTH + `CLUSTER_BITS)

`define CSR_ADDR_WIDTH  12
`define CORE_ID_WIDTH   8
`define CORE_BITS       2

`endif
`default_nettype wire

/* verilog/fabric_pkg.sv */
`include "fabric_cfg.svh"
`default_nettype none

package fabric_pkg;

    typedef enum logic {
        op_read,
        op_write
    } io_op_e;

    typedef struct packed {
        io_op_e                     op;
        logic [`IO_ADDR_WIDTH-1:0]  addr;
        logic [3:0]                 byteen;
        logic [`WORD_WIDTH-1:0]     data;
        logic [`IO_TAG_WIDTH-1:0]   tag;
    } io_req_t;

    typedef struct packed {
        io_op_e                     op;
        logic [`IO_ADDR_WIDTH-1:0]  addr;
        logic [3:0]                 byteen;
        logic [`WORD_WIDTH-1:0]     data;
        logic [`HOST_TAG_WIDTH-1:0] tag;
    } host_io_req_t;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0]     data;
        logic [`IO_TAG_WIDTH-1:0]   tag;
    } io_rsp_t;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0]     data;
        logic [`HOST_TAG_WIDTH-1:0] tag;
    } host_io_rsp_t;

    // Core id local to the cluster
    typedef struct packed {
        io_op_e                     op;
        logic [`CSR_ADDR_WIDTH-1:0] addr;
        logic [`WORD_WIDTH-1:0]     data;
        logic [`CORE_BITS-1:0]      core_id;
    } csr_req_t;

    typedef struct packed {
        io_op_e                     op;
        logic [`CSR_ADDR_WIDTH-1:0] addr;
        logic [`WORD_WIDTH-1:0]     data;
        logic [`CORE_ID_WIDTH-1:0]  core_id;
    } host_csr_req_t;

    typedef enum logic [1:0] {
        csr_idle,
        csr_fwd,
        csr_wait,
        csr_reply
    } csr_state_e;

endpackage

`default_nettype wire

/* verilog/io_req_arb.sv */
`timescale 1ns/100ps
`include "fabric_cfg.svh"
`default_nettype none

module io_req_arb (
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic [`NUM_CLUSTERS-1:0]                cl_req_valid,
    input  fabric_pkg::io_req_t [`NUM_CLUSTERS-1:0] cl_req,
    output logic [`NUM_CLUSTERS-1:0]                cl_req_ready,

    output logic                                    host_req_valid,
    output fabric_pkg::host_io_req_t                host_req,
    input  logic                                    host_req_ready
);
    import fabric_pkg::*;

    logic [`CLUSTER_BITS-1:0] rr_ptr;
    logic [`CLUSTER_BITS-1:0] grant_idx;
    logic                     grant_any;
    logic                     buf_free;
    logic                     accept;
    io_req_t                  grant_req;

    // First requester at or after the priority pointer
    always_comb begin
        int cand;
        grant_any = 1'b0;
        grant_idx = rr_ptr;
        for (int k = 0; k < `NUM_CLUSTERS; k++) begin
            cand = (int'(rr_ptr) + k) % `NUM_CLUSTERS;
            if (!grant_any && cl_req_valid[cand]) begin
                grant_any = 1'b1;
                grant_idx = `CLUSTER_BITS'(cand);
            end
        end
    end

    assign grant_req = cl_req[grant_idx];

    // Buffer can take a new item when empty or draining this edge
    assign buf_free = !host_req_valid || host_req_ready;
    assign accept   = grant_any && buf_free;

    always_comb begin
        cl_req_ready            = '0;
        cl_req_ready[grant_idx] = accept;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_req_valid <= 1'b0;
            rr_ptr         <= '0;
        end else begin
            if (accept) begin
                host_req_valid <= 1'b1;
                if (grant_idx == `CLUSTER_BITS'(`NUM_CLUSTERS - 1)) begin
                    rr_ptr <= '0;
                end else begin
                    rr_ptr <= grant_idx + 1'b1;
                end
            end else if (host_req_ready) begin
                host_req_valid <= 1'b0;
            end
        end
    end

    // Source cluster goes above the cluster tag
    always_ff @(posedge clk) begin
        if (accept) begin
            host_req.op     <= grant_req.op;
            host_req.addr   <= grant_req.addr;
            host_req.byteen <= grant_req.byteen;
            host_req.data   <= grant_req.data;
            host_req.tag    <= {grant_idx, grant_req.tag};
        end
    end

endmodule

`default_nettype wire

/* verilog/io_rsp_router.sv */
`timescale 1ns/100ps
`include "fabric_cfg.svh"
`default_nettype none

module io_rsp_router (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        host_rsp_valid,
    input  fabric_pkg::host_io_rsp_t    host_rsp,
    output logic                        host_rsp_ready,

    output logic [`NUM_CLUSTERS-1:0]    cl_rsp_valid,
    output fabric_pkg::io_rsp_t         cl_rsp,
    input  logic [`NUM_CLUSTERS-1:0]    cl_rsp_ready
);

    logic [`CLUSTER_BITS-1:0] dst_idx;
    logic [`NUM_CLUSTERS-1:0] dst_sel;
    logic                     buf_busy;
    logic                     drain;
    logic                     accept;

    // Destination cluster sits in the upper tag bits
    assign dst_idx = host_rsp.tag[`HOST_TAG_WIDTH-1 -: `CLUSTER_BITS];
    assign dst_sel = `NUM_CLUSTERS'(1) << dst_idx;

    // Valid is held one-hot, so only the target's ready matters
    assign buf_busy       = |cl_rsp_valid;
    assign drain          = |(cl_rsp_valid & cl_rsp_ready);
    assign host_rsp_ready = host_rsp_valid && (!buf_busy || drain);
    assign accept         = host_rsp_valid && host_rsp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cl_rsp_valid <= '0;
        end else if (accept) begin
            cl_rsp_valid <= dst_sel;
        end else if (drain) begin
            cl_rsp_valid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cl_rsp.data <= host_rsp.data;
            cl_rsp.tag  <= host_rsp.tag[`IO_TAG_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

/* verilog/csr_router.sv */
`timescale 1ns/100ps
`include "fabric_cfg.svh"
`default_nettype none

module csr_router (
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic                                    host_req_valid,
    input  fabric_pkg::host_csr_req_t               host_req,
    output logic                                    host_req_ready,

    output logic [`NUM_CLUSTERS-1:0]                cl_req_valid,
    output fabric_pkg::csr_req_t                    cl_req,
    input  logic [`NUM_CLUSTERS-1:0]                cl_req_ready,

    input  logic [`NUM_CLUSTERS-1:0]                cl_rsp_valid,
    input  logic [`NUM_CLUSTERS-1:0][`WORD_WIDTH-1:0] cl_rsp_data,
    output logic [`NUM_CLUSTERS-1:0]                cl_rsp_ready,

    output logic                                    host_rsp_valid,
    output logic [`WORD_WIDTH-1:0]                  host_rsp_data,
    input  logic                                    host_rsp_ready
);
    import fabric_pkg::*;

    csr_state_e               state;
    csr_state_e               state_next;
    logic [`CLUSTER_BITS-1:0] target;
    logic [`NUM_CLUSTERS-1:0] target_sel;
    logic                     host_fire;
    logic                     fwd_done;
    logic                     rsp_fire;

    assign target_sel = `NUM_CLUSTERS'(1) << target;

    assign host_req_ready = (state == csr_idle);
    assign cl_req_valid   = (state == csr_fwd) ? target_sel : '0;
    assign cl_rsp_ready   = (state == csr_wait) ? target_sel : '0;
    assign host_rsp_valid = (state == csr_reply);

    assign host_fire = host_req_valid && host_req_ready;
    assign fwd_done  = |(cl_req_valid & cl_req_ready);
    assign rsp_fire  = |(cl_rsp_valid & cl_rsp_ready);

    always_comb begin
        state_next = state;
        unique case (state)
            csr_idle:  if (host_fire) state_next = csr_fwd;
            csr_fwd:   if (fwd_done) state_next = csr_wait;
            csr_wait:  if (rsp_fire) state_next = csr_reply;
            csr_reply: if (host_rsp_ready) state_next = csr_idle;
            default:   state_next = csr_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= csr_idle;
        end else begin
            state <= state_next;
        end
    end

    // Upper core id bits pick the cluster, the low bits stay as local id
    always_ff @(posedge clk) begin
        if (host_fire) begin
            target         <= `CLUSTER_BITS'(host_req.core_id >> `CORE_BITS);
            cl_req.op      <= host_req.op;
            cl_req.addr    <= host_req.addr;
            cl_req.data    <= host_req.data;
            cl_req.core_id <= host_req.core_id[`CORE_BITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            host_rsp_data <= cl_rsp_data[target];
        end
    end

endmodule

`default_nettype wire

/* verilog/cluster_io_fabric.sv */
`timescale 1ns/100ps
`include "fabric_cfg.svh"
`default_nettype none

module cluster_io_fabric (
    input  logic                                        clk,
    input  logic                                        rst_n,

    // Cluster I/O requests and responses
    input  logic [`NUM_CLUSTERS-1:0]                    cl_io_req_valid,
    input  fabric_pkg::io_req_t [`NUM_CLUSTERS-1:0]     cl_io_req,
    output logic [`NUM_CLUSTERS-1:0]                    cl_io_req_ready,

    output logic [`NUM_CLUSTERS-1:0]                    cl_io_rsp_valid,
    output fabric_pkg::io_rsp_t                         cl_io_rsp,
    input  logic [`NUM_CLUSTERS-1:0]                    cl_io_rsp_ready,

    // Cluster CSR requests and responses
    output logic [`NUM_CLUSTERS-1:0]                    cl_csr_req_valid,
    output fabric_pkg::csr_req_t                        cl_csr_req,
    input  logic [`NUM_CLUSTERS-1:0]                    cl_csr_req_ready,

    input  logic [`NUM_CLUSTERS-1:0]                    cl_csr_rsp_valid,
    input  logic [`NUM_CLUSTERS-1:0][`WORD_WIDTH-1:0]   cl_csr_rsp_data,
    output logic [`NUM_CLUSTERS-1:0]                    cl_csr_rsp_ready,

    // Host I/O
    output logic                                        host_io_req_valid,
    output fabric_pkg::host_io_req_t                    host_io_req,
    input  logic                                        host_io_req_ready,

    input  logic                                        host_io_rsp_valid,
    input  fabric_pkg::host_io_rsp_t                    host_io_rsp,
    output logic                                        host_io_rsp_ready,

    // Host CSR
    input  logic                                        host_csr_req_valid,
    input  fabric_pkg::host_csr_req_t                   host_csr_req,
    output logic                                        host_csr_req_ready,

    output logic                                        host_csr_rsp_valid,
    output logic [`WORD_WIDTH-1:0]                      host_csr_rsp_data,
    input  logic                                        host_csr_rsp_ready,

    // Status
    input  logic [`NUM_CLUSTERS-1:0]                    cl_busy,
    input  logic [`NUM_CLUSTERS-1:0]                    cl_ebreak,
    output logic                                        busy,
    output logic                                        ebreak
);

    io_req_arb io_req_arb_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .cl_req_valid   (cl_io_req_valid),
        .cl_req         (cl_io_req),
        .cl_req_ready   (cl_io_req_ready),
        .host_req_valid (host_io_req_valid),
        .host_req       (host_io_req),
        .host_req_ready (host_io_req_ready)
    );

    io_rsp_router io_rsp_router_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .host_rsp_valid (host_io_rsp_valid),
        .host_rsp       (host_io_rsp),
        .host_rsp_ready (host_io_rsp_ready),
        .cl_rsp_valid   (cl_io_rsp_valid),
        .cl_rsp         (cl_io_rsp),
        .cl_rsp_ready   (cl_io_rsp_ready)
    );

    csr_router csr_router_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .host_req_valid (host_csr_req_valid),
        .host_req       (host_csr_req),
        .host_req_ready (host_csr_req_ready),
        .cl_req_valid   (cl_csr_req_valid),
        .cl_req         (cl_csr_req),
        .cl_req_ready   (cl_csr_req_ready),
        .cl_rsp_valid   (cl_csr_rsp_valid),
        .cl_rsp_data    (cl_csr_rsp_data),
        .cl_rsp_ready   (cl_csr_rsp_ready),
        .host_rsp_valid (host_csr_rsp_valid),
        .host_rsp_data  (host_csr_rsp_data),
        .host_rsp_ready (host_csr_rsp_ready)
    );

    // Any cluster busy or stopped marks the whole device
    assign busy   = |cl_busy;
    assign ebreak = |cl_ebreak;

endmodule

`default_nettype wire

/* testbench/fabric_assertions.sv */
`timescale 1ns/100ps
`include "fabric_cfg.svh"
`default_nettype none

module fabric_assertions (
    input  logic                                        clk,
    input  logic                                        rst_n,

    input  logic                                        host_io_req_valid,
    input  logic                                        host_io_req_ready,
    input  fabric_pkg::host_io_req_t                    host_io_req,

    input  logic [`NUM_CLUSTERS-1:0]                    cl_io_rsp_valid,
    input  logic [`NUM_CLUSTERS-1:0]                    cl_io_rsp_ready,
    input  fabric_pkg::io_rsp_t                         cl_io_rsp,

    input  logic [`NUM_CLUSTERS-1:0]                    cl_csr_req_valid,
    input  logic [`NUM_CLUSTERS-1:0]                    cl_csr_req_ready,
    input  fabric_pkg::csr_req_t                        cl_csr_req,

    input  logic                                        host_csr_rsp_valid,
    input  logic                                        host_csr_rsp_ready,
    input  logic [`WORD_WIDTH-1:0]                      host_csr_rsp_data
);

    // Stalled channels keep valid and payload
    host_io_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        host_io_req_valid && !host_io_req_ready |=> host_io_req_valid && $stable(host_io_req))
        else $error("host I/O request changed while stalled");

    cl_io_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (|cl_io_rsp_valid) && !(|(cl_io_rsp_valid & cl_io_rsp_ready))
        |=> $stable(cl_io_rsp_valid) && $stable(cl_io_rsp))
        else $error("cluster I/O response changed while stalled");

    cl_csr_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (|cl_csr_req_valid) && !(|(cl_csr_req_valid & cl_csr_req_ready))
        |=> $stable(cl_csr_req_valid) && $stable(cl_csr_req))
        else $error("cluster CSR request changed while stalled");

    host_csr_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        host_csr_rsp_valid && !host_csr_rsp_ready
        |=> host_csr_rsp_valid && $stable(host_csr_rsp_data))
        else $error("host CSR response changed while stalled");

    // Outputs quiet in reset and on the first edge after it
    reset_quiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> !host_io_req_valid && (cl_io_rsp_valid == '0)
        && (cl_csr_req_valid == '0) && !host_csr_rsp_valid)
        else $error("valid output high during or right after reset");

    csr_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(cl_csr_req_valid))
        else $error("more than one cluster CSR request valid");

endmodule

bind cluster_io_fabric fabric_assertions fabric_assertions_inst (.*);

`default_nettype wire

/* testbench/tb_cluster_io_fabric.sv */
`timescale 1ns/100ps
`include "fabric_cfg.svh"
`default_nettype none

module tb_cluster_io_fabric;
    import fabric_pkg::*;

    typedef struct packed {
        logic [`CLUSTER_BITS-1:0] cl;
        io_rsp_t                  rsp;
    } rsp_exp_t;

    logic                                      clk;
    logic                                      rst_n;
    logic [`NUM_CLUSTERS-1:0]                  cl_io_req_valid;
    io_req_t [`NUM_CLUSTERS-1:0]               cl_io_req;
    logic [`NUM_CLUSTERS-1:0]                  cl_io_req_ready;
    logic [`NUM_CLUSTERS-1:0]                  cl_io_rsp_valid;
    io_rsp_t                                   cl_io_rsp;
    logic [`NUM_CLUSTERS-1:0]                  cl_io_rsp_ready;
    logic [`NUM_CLUSTERS-1:0]                  cl_csr_req_valid;
    csr_req_t                                  cl_csr_req;
    logic [`NUM_CLUSTERS-1:0]                  cl_csr_req_ready;
    logic [`NUM_CLUSTERS-1:0]                  cl_csr_rsp_valid;
    logic [`NUM_CLUSTERS-1:0][`WORD_WIDTH-1:0] cl_csr_rsp_data;
    logic [`NUM_CLUSTERS-1:0]                  cl_csr_rsp_ready;
    logic                                      host_io_req_valid;
    host_io_req_t                              host_io_req;
    logic                                      host_io_req_ready;
    logic                                      host_io_rsp_valid;
    host_io_rsp_t                              host_io_rsp;
    logic                                      host_io_rsp_ready;
    logic                                      host_csr_req_valid;
    host_csr_req_t                             host_csr_req;
    logic                                      host_csr_req_ready;
    logic                                      host_csr_rsp_valid;
    logic [`WORD_WIDTH-1:0]                    host_csr_rsp_data;
    logic                                      host_csr_rsp_ready;
    logic [`NUM_CLUSTERS-1:0]                  cl_busy;
    logic [`NUM_CLUSTERS-1:0]                  cl_ebreak;
    logic                                      busy;
    logic                                      ebreak;

    logic [31:0] seed = 32'h05374369;
    int          errors = 0;
    // Expected round-robin pointer
    int          rr_expect = 0;

    cluster_io_fabric cluster_io_fabric_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic io_req_t rand_io_req();
        io_req_t     r;
        logic [31:0] a;
        logic [31:0] b;
        a = lcg_next();
        b = lcg_next();
        r.op     = io_op_e'(a[1]);
        r.addr   = a[31:2];
        r.byteen = b[31:28];
        r.tag    = b[23:16];
        r.data   = lcg_next();
        return r;
    endfunction

    function automatic host_io_rsp_t rand_host_rsp();
        host_io_rsp_t r;
        logic [31:0]  a;
        a = lcg_next();
        r.tag  = a[31:22];
        r.data = lcg_next();
        return r;
    endfunction

    function automatic host_csr_req_t rand_csr_req();
        host_csr_req_t r;
        logic [31:0]   a;
        a = lcg_next();
        r.op      = io_op_e'(a[27]);
        r.addr    = a[23:12];
        // Core ids stay inside the populated clusters
        r.core_id = `CORE_ID_WIDTH'(a[31:28]);
        r.data    = lcg_next();
        return r;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic run_io_requests(input int per_cluster, input bit random_ready);
        int           remaining [`NUM_CLUSTERS];
        host_io_req_t exp_q[$];
        host_io_req_t exp;
        int           grant;
        int           cand;
        int           timeout;
        bit           can_take;
        logic [31:0]  r;
        timeout = 0;
        @(posedge clk);
        for (int c = 0; c < `NUM_CLUSTERS; c++) begin
            remaining[c] = per_cluster - 1;
            cl_io_req_valid[c] <= 1'b1;
            cl_io_req[c]       <= rand_io_req();
        end
        while (1) begin
            @(negedge clk);
            assert (host_io_req_valid == (exp_q.size() != 0))
                else report_error($sformatf("host I/O request valid %b, expected %b",
                                            host_io_req_valid, exp_q.size() != 0));
            grant = -1;
            for (int k = 0; k < `NUM_CLUSTERS; k++) begin
                cand = (rr_expect + k) % `NUM_CLUSTERS;
                if (grant < 0 && cl_io_req_valid[cand]) grant = cand;
            end
            can_take = (exp_q.size() == 0) || host_io_req_ready;
            for (int c = 0; c < `NUM_CLUSTERS; c++) begin
                assert (cl_io_req_ready[c] == (can_take && grant == c))
                    else report_error($sformatf("cluster %0d request ready wrong", c));
            end
            if (host_io_req_valid && host_io_req_ready) begin
                if (exp_q.size() == 0) begin
                    report_error("host I/O request with nothing accepted");
                end else begin
                    exp = exp_q.pop_front();
                    assert (host_io_req == exp)
                        else report_error($sformatf("host I/O request %h, expected %h",
                                                    host_io_req, exp));
                end
            end
            if (grant >= 0 && can_take) begin
                exp.op     = cl_io_req[grant].op;
                exp.addr   = cl_io_req[grant].addr;
                exp.byteen = cl_io_req[grant].byteen;
                exp.data   = cl_io_req[grant].data;
                exp.tag    = {`CLUSTER_BITS'(grant), cl_io_req[grant].tag};
                exp_q.push_back(exp);
                rr_expect = (grant + 1) % `NUM_CLUSTERS;
            end
            if (cl_io_req_valid == '0 && !host_io_req_valid) break;
            timeout++;
            if (timeout > 2000) abort_on_timeout("I/O requests to reach the host");
            @(posedge clk);
            if (grant >= 0 && can_take) begin
                if (remaining[grant] > 0) begin
                    cl_io_req[grant] <= rand_io_req();
                    remaining[grant]--;
                end else begin
                    cl_io_req_valid[grant] <= 1'b0;
                end
            end
            r = lcg_next();
            host_io_req_ready <= random_ready ? r[31] : 1'b1;
        end
        assert (exp_q.size() == 0) else report_error("accepted I/O request never reached host");
        @(posedge clk);
        host_io_req_ready <= 1'b1;
    endtask

    task automatic run_io_responses(input int count);
        rsp_exp_t    q[$];
        rsp_exp_t    e;
        int          left;
        int          timeout;
        bit          accepted;
        logic [31:0] r;
        timeout = 0;
        @(posedge clk);
        host_io_rsp_valid <= 1'b1;
        host_io_rsp       <= rand_host_rsp();
        left = count - 1;
        while (1) begin
            @(negedge clk);
            if (host_io_rsp_valid) begin
                assert (host_io_rsp_ready == (q.size() == 0 || cl_io_rsp_ready[q[0].cl]))
                    else report_error($sformatf("host I/O response ready %b wrong",
                                                host_io_rsp_ready));
            end
            if (|cl_io_rsp_valid) begin
                if (q.size() == 0) begin
                    report_error("cluster I/O response with nothing accepted");
                end else begin
                    e = q[0];
                    assert (cl_io_rsp_valid == (`NUM_CLUSTERS'(1) << e.cl))
                        else report_error($sformatf("response valid %b, expected cluster %0d",
                                                    cl_io_rsp_valid, e.cl));
                    assert (cl_io_rsp == e.rsp)
                        else report_error($sformatf("cluster I/O response %h, expected %h",
                                                    cl_io_rsp, e.rsp));
                    if (|(cl_io_rsp_valid & cl_io_rsp_ready)) void'(q.pop_front());
                end
            end
            accepted = host_io_rsp_valid && host_io_rsp_ready;
            if (accepted) begin
                e.cl       = host_io_rsp.tag[`HOST_TAG_WIDTH-1 -: `CLUSTER_BITS];
                e.rsp.tag  = host_io_rsp.tag[`IO_TAG_WIDTH-1:0];
                e.rsp.data = host_io_rsp.data;
                q.push_back(e);
            end
            if (!host_io_rsp_valid && cl_io_rsp_valid == '0 && q.size() == 0) break;
            timeout++;
            if (timeout > 2000) abort_on_timeout("I/O responses to reach the clusters");
            @(posedge clk);
            if (accepted) begin
                if (left > 0) begin
                    host_io_rsp <= rand_host_rsp();
                    left--;
                end else begin
                    host_io_rsp_valid <= 1'b0;
                end
            end
            r = lcg_next();
            cl_io_rsp_ready <= r[31:28];
        end
        @(posedge clk);
        cl_io_rsp_ready <= '1;
    endtask

    task automatic run_csr(input int count);
        host_csr_req_t cur;
        int            left;
        int            timeout;
        int            k;
        bit            in_flight;
        bit            host_fire;
        bit            cl_fire;
        bit            rsp_fire;
        logic [31:0]   rsp_word;
        logic [31:0]   r;
        timeout   = 0;
        in_flight = 1'b0;
        k         = 0;
        rsp_word  = '0;
        @(posedge clk);
        host_csr_req_valid <= 1'b1;
        host_csr_req       <= rand_csr_req();
        left = count - 1;
        while (1) begin
            @(negedge clk);
            assert (host_csr_req_ready == !in_flight)
                else report_error("host CSR ready wrong while a request is in flight");
            host_fire = host_csr_req_valid && host_csr_req_ready;
            cl_fire   = |(cl_csr_req_valid & cl_csr_req_ready);
            rsp_fire  = |(cl_csr_rsp_valid & cl_csr_rsp_ready);
            if (cl_csr_req_valid != '0) begin
                assert (cl_csr_req_valid == (`NUM_CLUSTERS'(1) << k))
                    else report_error($sformatf("CSR valid %b, expected cluster %0d",
                                                cl_csr_req_valid, k));
                assert (cl_csr_req.op == cur.op && cl_csr_req.addr == cur.addr
                        && cl_csr_req.data == cur.data
                        && cl_csr_req.core_id == cur.core_id[`CORE_BITS-1:0])
                    else report_error($sformatf("cluster CSR request %h wrong for %h",
                                                cl_csr_req, cur));
            end
            if (in_flight) begin
                assert ((cl_csr_rsp_ready & ~(`NUM_CLUSTERS'(1) << k)) == '0)
                    else report_error("CSR response ready to a cluster not addressed");
            end
            if (host_csr_rsp_valid && host_csr_rsp_ready) begin
                assert (host_csr_rsp_data == rsp_word)
                    else report_error($sformatf("host CSR data %h, expected %h",
                                                host_csr_rsp_data, rsp_word));
                in_flight = 1'b0;
            end
            if (host_fire) begin
                cur       = host_csr_req;
                k         = int'(host_csr_req.core_id >> `CORE_BITS);
                in_flight = 1'b1;
            end
            if (cl_fire) rsp_word = lcg_next();
            if (!host_csr_req_valid && !in_flight) break;
            timeout++;
            if (timeout > 2000) abort_on_timeout("CSR transactions to complete");
            @(posedge clk);
            if (host_fire) begin
                if (left > 0) begin
                    host_csr_req <= rand_csr_req();
                    left--;
                end else begin
                    host_csr_req_valid <= 1'b0;
                end
            end
            if (cl_fire) begin
                cl_csr_rsp_valid[k] <= 1'b1;
                cl_csr_rsp_data[k]  <= rsp_word;
            end
            if (rsp_fire) cl_csr_rsp_valid <= '0;
            r = lcg_next();
            cl_csr_req_ready   <= r[31:28];
            host_csr_rsp_ready <= r[27];
        end
    endtask

    task automatic check_status(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            r = lcg_next();
            cl_busy   <= r[31:28];
            cl_ebreak <= r[27:24];
            @(negedge clk);
            assert (busy == |cl_busy && ebreak == |cl_ebreak)
                else report_error($sformatf("busy %b ebreak %b for %b %b",
                                            busy, ebreak, cl_busy, cl_ebreak));
        end
    endtask

    initial begin
        rst_n              = 1'b0;
        cl_io_req_valid    = '0;
        cl_io_req          = '0;
        cl_io_rsp_ready    = '1;
        cl_csr_req_ready   = '0;
        cl_csr_rsp_valid   = '0;
        cl_csr_rsp_data    = '0;
        host_io_req_ready  = 1'b1;
        host_io_rsp_valid  = 1'b0;
        host_io_rsp        = '0;
        host_csr_req_valid = 1'b0;
        host_csr_req       = '0;
        host_csr_rsp_ready = 1'b0;
        cl_busy            = '0;
        cl_ebreak          = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // All four at once, grants expected in order 0 to 3
        run_io_requests(1, 1'b0);
        run_io_requests(8, 1'b1);
        run_io_responses(40);
        run_csr(16);
        check_status(24);

        $display("Check errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/fabric_pkg.sv
verilog/io_req_arb.sv
verilog/io_rsp_router.sv
verilog/csr_router.sv
verilog/cluster_io_fabric.sv
testbench/fabric_assertions.sv
testbench/tb_cluster_io_fabric.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_cluster_io_fabric -o sim \
    && ./obj_dir/sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
